// ==== project.f ====
src/hc_pkg.sv
src/line_fifo.sv
src/ring_writer.sv
src/write_channel.sv
src/ring_status.sv
src/host_channel_top.sv
verification/host_channel_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the host channel testbench with Verilator and run it once
set -e

cd "$(dirname "$0")"
rm -f sim.log

verilator --binary --timing --assert -j 0 \
    --top-module host_channel_tb \
    -f project.f \
    -o host_channel_sim

./obj_dir/host_channel_sim | tee sim.log

if grep -qx "All tests passed" sim.log
then
    echo "Simulation result: PASS"
else
    echo "Simulation result: FAIL"
    exit 1
fi

// ==== verification/host_channel_tb.sv ====
module host_channel_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RING_IDX_BITS   = hc_pkg::RING_IDX_BITS_DEFAULT;
    localparam int IDLE_FLUSH_BITS = hc_pkg::IDLE_FLUSH_BITS_DEFAULT;
    localparam int RING_SIZE       = 1 << RING_IDX_BITS;
    localparam int QUARTER_LINES   = RING_SIZE / 4;
    localparam hc_pkg::line_addr_t BASE_ADDR = 32'h0004_0fe0;
    localparam hc_pkg::wr_req_t FENCE_REQ = '{kind: hc_pkg::REQ_FENCE, addr: '0, data: '0};

    localparam int RESET_CYCLES   = 16;
    localparam int PAUSE_CYCLES   = 60;
    localparam int ACK_DELAY_BITS = 2;
    localparam int ACK_DELAY_MAX  = (1 << ACK_DELAY_BITS) - 1;
    localparam int STREAM_LINES   = 150;
    localparam int BURST_LINES    = 64;
    localparam int HOLD_LINES     = 80;
    localparam int TOTAL_LINES    = STREAM_LINES + BURST_LINES + HOLD_LINES + 3;
    // Each line costs a handshake plus a share of fences and tx gaps
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + TOTAL_LINES * 2 * (6 + ACK_DELAY_MAX)
                                    + 8 * PAUSE_CYCLES;

    // One write as the host saw it, with the published index at that moment
    typedef struct packed
    {
        hc_pkg::wr_req_t   req;
        hc_pkg::ring_idx_t published;
    } mem_write_t;

    logic              clk;
    logic              reset;
    hc_pkg::hc_csr_t   csr;
    hc_pkg::cl_data_t  tx_data;
    logic              tx_enable;
    logic              tx_rdy;
    logic              mem_req;
    hc_pkg::wr_req_t   mem_req_data;
    logic              mem_ack;
    hc_pkg::ring_idx_t consume_idx;
    hc_pkg::ring_idx_t next_write_idx;

    logic [31:0] lfsr_state = 32'hc389_cbae;
    mem_write_t  mem_log [$];
    int          sent_count = 0;
    int          lines_seen = 0;
    int          lines_since_fence = 0;
    int          consumed_total = 0;
    int          cycle_count = 0;
    logic        last_was_fence = 1'b0;
    logic        hold_consume = 1'b0;
    logic        quiet_window = 1'b0;
    logic        mem_req_prev = 1'b0;

    host_channel_top #(.RING_IDX_BITS(RING_IDX_BITS), .IDLE_FLUSH_BITS(IDLE_FLUSH_BITS))
    host_channel_top_inst
    (
        .clk, .reset, .csr,
        .tx_data, .tx_enable, .tx_rdy,
        .mem_req, .mem_req_data, .mem_ack,
        .consume_idx, .next_write_idx
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ============================================================
    // Random bits, reference model and checks
    // ============================================================

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0])
        begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    // One LFSR step per bit handed out
    function automatic int random_bits(input int count);
        int value;
        int i;
        value = 0;
        for (i = 0; i < count; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
        return value;
    endfunction

    function automatic hc_pkg::cl_data_t line_data(input int n);
        return {32'h0c1a_0000 ^ 32'(n), 32'(n) * 32'h9e37_79b9};
    endfunction

    // Line n lands at the ring entry n modulo the ring size
    function automatic hc_pkg::wr_req_t expected_line(input int n);
        hc_pkg::wr_req_t req;
        req.kind = hc_pkg::REQ_WRLINE;
        req.addr = BASE_ADDR + hc_pkg::line_addr_t'(n % RING_SIZE);
        req.data = line_data(n);
        return req;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_req(input string name, input hc_pkg::wr_req_t got,
                             input hc_pkg::wr_req_t expected);
        if (got !== expected)
        begin
            abort_run($sformatf("FAILED %s: got %h expected %h", name, got, expected));
        end
    endtask

    task automatic check_idx(input string name, input hc_pkg::ring_idx_t got,
                             input hc_pkg::ring_idx_t expected);
        if (got !== expected)
        begin
            abort_run($sformatf("FAILED %s: got %h expected %h", name, got, expected));
        end
    endtask

    // ============================================================
    // Host memory, consumer and monitors
    // ============================================================

    // Four-phase responder that logs each request once, at its first sight
    initial
    begin
        mem_ack = 1'b0;
        forever
        begin
            @(negedge clk);
            if (mem_req && !mem_ack)
            begin
                mem_log.push_back('{req: mem_req_data, published: next_write_idx});
                repeat (random_bits(ACK_DELAY_BITS)) @(negedge clk);
                @(posedge clk);
                mem_ack <= 1'b1;
                do @(negedge clk); while (mem_req);
                @(posedge clk);
                mem_ack <= 1'b0;
            end
        end
    end

    // Host frees entries it was told about, lagging by a random amount
    initial
    begin
        int pending;
        int step;
        consume_idx = '0;
        forever
        begin
            @(negedge clk);
            pending = int'(hc_pkg::ring_idx_t'(next_write_idx - consume_idx));
            step    = hold_consume ? 0 : random_bits(2);
            if (step > pending)
            begin
                step = pending;
            end
            @(posedge clk);
            consume_idx    <= consume_idx + hc_pkg::ring_idx_t'(step);
            consumed_total += step;
        end
    end

    initial
    begin
        forever
        begin
            @(negedge clk);
            if (mem_req && !mem_req_prev && mem_ack)
            begin
                abort_run("mem_req rose while mem_ack was still high");
            end
            if (mem_req && quiet_window)
            begin
                abort_run("mem_req was raised while csr.enable was low");
            end
            mem_req_prev = mem_req;
        end
    end

    initial
    begin
        forever
        begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count > TIMEOUT_CYCLES)
            begin
                abort_run($sformatf("Timeout after %0d cycles, the run stopped making progress",
                                    cycle_count));
            end
        end
    end

    // Compares every logged write against the reference in arrival order
    initial
    begin
        mem_write_t rec;
        forever
        begin
            @(posedge clk);
            while (mem_log.size() != 0)
            begin
                rec = mem_log.pop_front();
                if (rec.req.kind == hc_pkg::REQ_FENCE)
                begin
                    check_req("mem_req_data", rec.req, FENCE_REQ);
                    check_idx("next_write_idx", rec.published,
                              hc_pkg::ring_idx_t'(lines_seen % RING_SIZE));
                    lines_since_fence = 0;
                    last_was_fence    = 1'b1;
                end
                else
                begin
                    check_req($sformatf("mem_req_data line %0d", lines_seen), rec.req,
                              expected_line(lines_seen));
                    lines_seen++;
                    lines_since_fence++;
                    last_was_fence = 1'b0;
                    // The line granted on the cycle the FSM turns to the fence adds one
                    if (lines_since_fence > QUARTER_LINES + 1)
                    begin
                        abort_run("No fence within a quarter of the ring of streamed lines");
                    end
                    if (lines_seen - consumed_total > RING_SIZE - 1)
                    begin
                        abort_run("Lines were written over entries the host had not consumed");
                    end
                end
            end
        end
    end

    // ============================================================
    // Stimulus
    // ============================================================

    // Called just after a rising edge and returns on the handshake edge
    task automatic send_line(input logic with_gaps);
        int gap;
        tx_enable <= 1'b1;
        tx_data   <= line_data(sent_count);
        @(negedge clk);
        while (!tx_rdy)
        begin
            @(negedge clk);
        end
        @(posedge clk);
        sent_count++;
        gap = with_gaps ? random_bits(2) : 0;
        if (gap != 0)
        begin
            tx_enable <= 1'b0;
            repeat (gap) @(posedge clk);
        end
    endtask

    task automatic send_lines(input int count, input logic with_gaps);
        repeat (count) send_line(with_gaps);
        tx_enable <= 1'b0;
    endtask

    // Idle long enough for the idle flush, then expect everything fenced
    task automatic pause_and_check_fence();
        do @(negedge clk); while (lines_seen != sent_count);
        repeat (PAUSE_CYCLES) @(negedge clk);
        if (!last_was_fence)
        begin
            abort_run("No fence was written after the tx pause");
        end
        check_idx("next_write_idx", next_write_idx, hc_pkg::ring_idx_t'(lines_seen % RING_SIZE));
        @(posedge clk);
    endtask

    initial
    begin
        int held_lines;
        reset     = 1'b1;
        csr       = '{enable: 1'b1, base_addr: BASE_ADDR};
        tx_enable = 1'b0;
        tx_data   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        // Gapped traffic wraps the ring twice
        send_lines(STREAM_LINES, 1'b1);
        pause_and_check_fence();

        // Back to back traffic relies on the quarter-ring fence
        send_lines(BURST_LINES, 1'b0);
        pause_and_check_fence();

        // The host stops consuming and the ring must stop one entry short
        hold_consume = 1'b1;
        fork
            send_lines(HOLD_LINES, 1'b0);
            begin
                do @(negedge clk); while (lines_seen - consumed_total < RING_SIZE - 1);
                repeat (PAUSE_CYCLES) @(negedge clk);
                if (lines_seen - consumed_total != RING_SIZE - 1)
                begin
                    abort_run("The ring did not stop exactly one entry short of full");
                end
                hold_consume = 1'b0;
            end
        join
        pause_and_check_fence();

        // Disabled channel holds lines until it is enabled again
        quiet_window = 1'b1;
        csr.enable  <= 1'b0;
        fork
            send_lines(3, 1'b0);
            begin
                do @(negedge clk); while (tx_rdy);
                held_lines = lines_seen;
                repeat (PAUSE_CYCLES) @(negedge clk);
                if (lines_seen != held_lines || tx_rdy)
                begin
                    abort_run("Lines moved while the channel was disabled");
                end
                @(posedge clk);
                quiet_window = 1'b0;
                csr.enable  <= 1'b1;
            end
        join
        pause_and_check_fence();

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== src/host_channel_top.sv ====
module host_channel_top
#(
    parameter int RING_IDX_BITS   = hc_pkg::RING_IDX_BITS_DEFAULT,
    parameter int IDLE_FLUSH_BITS = hc_pkg::IDLE_FLUSH_BITS_DEFAULT
)
(
    input  logic              clk,
    input  logic              reset,

    input  hc_pkg::hc_csr_t   csr,

    // Producer side
    input  hc_pkg::cl_data_t  tx_data,
    input  logic              tx_enable,
    output logic              tx_rdy,

    // Host memory write port
    output logic              mem_req,
    output hc_pkg::wr_req_t   mem_req_data,
    input  logic              mem_ack,

    // Host ring indices
    input  hc_pkg::ring_idx_t consume_idx,
    output hc_pkg::ring_idx_t next_write_idx
);

    logic                   wr_request;
    hc_pkg::wr_req_t        wr_req;
    hc_pkg::channel_grant_t channel_grant;
    hc_pkg::ring_status_t   status;
    hc_pkg::ring_idx_t      written_idx;

    ring_writer #(.RING_IDX_BITS(RING_IDX_BITS), .IDLE_FLUSH_BITS(IDLE_FLUSH_BITS))
    ring_writer_inst
    (
        .clk, .reset, .csr,
        .tx_data, .tx_enable, .tx_rdy,
        .wr_request, .wr_req, .grant_in(channel_grant),
        .status, .written_idx
    );

    write_channel write_channel_inst
    (
        .clk, .reset,
        .wr_request, .wr_req, .grant_out(channel_grant),
        .mem_req, .mem_req_data, .mem_ack
    );

    ring_status #(.RING_IDX_BITS(RING_IDX_BITS)) ring_status_inst
    (
        .clk, .reset,
        .consume_idx, .written_idx,
        .status, .next_write_idx
    );

endmodule

// ==== src/ring_status.sv ====
module ring_status
#(
    parameter int RING_IDX_BITS = hc_pkg::RING_IDX_BITS_DEFAULT
)
(
    input  logic                 clk,
    input  logic                 reset,

    input  hc_pkg::ring_idx_t    consume_idx,
    input  hc_pkg::ring_idx_t    written_idx,

    output hc_pkg::ring_status_t status,
    output hc_pkg::ring_idx_t    next_write_idx
);

    hc_pkg::ring_idx_t oldest_q;
    hc_pkg::ring_idx_t published_q;

    // Host consume index and the published fence index, one register each
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            oldest_q    <= '0;
            published_q <= '0;
        end
        else
        begin
            oldest_q    <= consume_idx;
            published_q <= written_idx;
        end
    end

    assign status.oldest_idx = oldest_q;
    assign next_write_idx    = published_q;

    // Distances around the ring, measured from the last consume index
    logic [RING_IDX_BITS-1:0] pending_dist;
    logic [RING_IDX_BITS-1:0] advance_dist;
    assign pending_dist = published_q - oldest_q;
    assign advance_dist = consume_idx - oldest_q;

    // The host may only free entries that were already published
    assert property (@(posedge clk) disable iff (reset) advance_dist <= pending_dist);

endmodule

// ==== src/write_channel.sv ====
module write_channel
(
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   wr_request,
    input  hc_pkg::wr_req_t        wr_req,
    output hc_pkg::channel_grant_t grant_out,

    output logic                   mem_req,
    output hc_pkg::wr_req_t        mem_req_data,
    input  logic                   mem_ack
);

    logic            out_not_full;
    logic            out_not_empty;
    logic            out_deq;
    hc_pkg::wr_req_t out_first;

    // ============================================================
    // Grant into the outgoing buffer
    // ============================================================

    // A request is taken the same cycle it is raised if there is room
    assign grant_out.can_issue = out_not_full;
    assign grant_out.grant     = wr_request && out_not_full;

    line_fifo #(.payload_t(hc_pkg::wr_req_t)) out_fifo
    (
        .clk,
        .reset,
        .enq_data  (wr_req),
        .enq_en    (grant_out.grant),
        .not_full  (out_not_full),
        .first     (out_first),
        .deq_en    (out_deq),
        .not_empty (out_not_empty)
    );

    // ============================================================
    // Four-phase handshake to host memory
    // ============================================================

    typedef enum logic [1:0]
    {
        IDLE,
        WAIT_ACK,
        WAIT_RELEASE
    } hs_state_t;

    hs_state_t hs_state;

    // Request is a decoded register, so it leaves the block glitch free
    assign mem_req      = (hs_state == WAIT_ACK);
    // Head of the buffer does not move until the ack, which keeps data stable
    assign mem_req_data = out_first;
    assign out_deq      = (hs_state == WAIT_ACK) && mem_ack;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            hs_state <= IDLE;
        end
        else
        begin
            case (hs_state)
                IDLE:
                begin
                    // Ack is already low here, the previous cycle saw it drop
                    if (out_not_empty)
                    begin
                        hs_state <= WAIT_ACK;
                    end
                end
                WAIT_ACK:
                begin
                    if (mem_ack)
                    begin
                        hs_state <= WAIT_RELEASE;
                    end
                end
                default:
                begin
                    if (!mem_ack)
                    begin
                        hs_state <= IDLE;
                    end
                end
            endcase
        end
    end

    // The host samples data at any point while the request waits for its ack
    assert property (@(posedge clk) disable iff (reset)
                     (mem_req && !mem_ack) |=> $stable(mem_req_data));

endmodule

// ==== src/ring_writer.sv ====
module ring_writer
#(
    parameter int RING_IDX_BITS   = hc_pkg::RING_IDX_BITS_DEFAULT,
    parameter int IDLE_FLUSH_BITS = hc_pkg::IDLE_FLUSH_BITS_DEFAULT
)
(
    input  logic                   clk,
    input  logic                   reset,

    input  hc_pkg::hc_csr_t        csr,

    input  hc_pkg::cl_data_t       tx_data,
    input  logic                   tx_enable,
    output logic                   tx_rdy,

    output logic                   wr_request,
    output hc_pkg::wr_req_t        wr_req,
    input  hc_pkg::channel_grant_t grant_in,

    input  hc_pkg::ring_status_t   status,
    output hc_pkg::ring_idx_t      written_idx
);

    // Bit of the index that toggles every quarter of the ring
    localparam int QUARTER_BIT = RING_IDX_BITS - 2;

    hc_pkg::cl_data_t  line_data;
    logic              line_not_empty;
    logic              line_deq;
    logic              line_accept;

    // Producer handshake completes only when the buffer has room
    assign line_accept = tx_enable && tx_rdy;

    line_fifo #(.payload_t(hc_pkg::cl_data_t)) in_fifo
    (
        .clk,
        .reset,
        .enq_data  (tx_data),
        .enq_en    (line_accept),
        .not_full  (tx_rdy),
        .first     (line_data),
        .deq_en    (line_deq),
        .not_empty (line_not_empty)
    );

    // ============================================================
    // Ring pointers and the flush decision
    // ============================================================

    // Next entry to be written
    hc_pkg::ring_idx_t cur_idx;

    typedef enum logic [1:0]
    {
        WAIT_EMPTY,
        WAIT_DATA,
        EMIT_FENCE
    } state_t;

    state_t state;

    // Writing a quarter of the ring since the last publish forces a fence
    logic flush_for_writes;
    assign flush_for_writes = (cur_idx[QUARTER_BIT] != written_idx[QUARTER_BIT]);

    logic [IDLE_FLUSH_BITS-1:0] idle_cycles;
    logic                       flush_for_idle;

    // Saturation of the idle counter requests a fence
    assign flush_for_idle = idle_cycles[IDLE_FLUSH_BITS-1];

    // A line leaves the input buffer only when its own write was granted
    assign line_deq = grant_in.grant && (state != EMIT_FENCE);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            idle_cycles <= '0;
        end
        else
        begin
            // Only count while the channel could take a write but none came,
            // so a saturated memory port does not trigger extra fences
            if ((state != WAIT_DATA) || line_deq)
            begin
                idle_cycles <= '0;
            end
            else if (grant_in.can_issue)
            begin
                idle_cycles <= idle_cycles + 1'b1;
            end
        end
    end

    // ============================================================
    // State machine
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= WAIT_EMPTY;
            cur_idx     <= '0;
            written_idx <= '0;
        end
        else
        begin
            case (state)
                WAIT_EMPTY:
                begin
                    // First line after a fence opens a new batch
                    if (grant_in.grant)
                    begin
                        state   <= WAIT_DATA;
                        cur_idx <= cur_idx + 1'b1;
                    end
                end
                WAIT_DATA:
                begin
                    if (grant_in.grant)
                    begin
                        cur_idx <= cur_idx + 1'b1;
                    end
                    if (flush_for_idle || flush_for_writes)
                    begin
                        state <= EMIT_FENCE;
                    end
                end
                default:
                begin
                    // The fence makes everything before cur_idx visible
                    if (grant_in.grant)
                    begin
                        state       <= WAIT_EMPTY;
                        written_idx <= cur_idx;
                    end
                end
            endcase
        end
    end

    // ============================================================
    // Write request formation
    // ============================================================

    // Stop one short of the oldest live entry so a full ring is never overrun
    logic allow_write;
    assign allow_write = (hc_pkg::ring_idx_t'(cur_idx + 1'b1) != status.oldest_idx);

    assign wr_request = csr.enable && allow_write &&
                        (line_not_empty || (state == EMIT_FENCE));

    always_comb
    begin
        wr_req.kind = hc_pkg::REQ_WRLINE;
        wr_req.addr = csr.base_addr + hc_pkg::line_addr_t'(cur_idx);
        wr_req.data = line_data;
        if (state == EMIT_FENCE)
        begin
            wr_req.kind = hc_pkg::REQ_FENCE;
            wr_req.addr = '0;
            wr_req.data = '0;
        end
    end

endmodule

// ==== src/line_fifo.sv ====
module line_fifo
#(
    parameter type payload_t = logic
)
(
    input  logic     clk,
    input  logic     reset,

    input  payload_t enq_data,
    input  logic     enq_en,
    output logic     not_full,

    output payload_t first,
    input  logic     deq_en,
    output logic     not_empty
);

    // Two storage slots, addressed by the head pointer
    payload_t   slots [2];
    logic       head;
    logic [1:0] count;
    logic       tail;

    // The free slot sits one past the head when one entry is held
    assign tail      = head ^ count[0];
    assign not_full  = (count != 2'd2);
    assign not_empty = (count != 2'd0);
    assign first     = slots[head];

    // Enqueue writes the slot at the tail
    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            slots[tail] <= enq_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            head  <= 1'b0;
            count <= 2'd0;
        end
        else
        begin
            if (deq_en)
            begin
                head <= ~head;
            end
            count <= count + {1'b0, enq_en} - {1'b0, deq_en};
        end
    end

    // Callers must honor the flags
    assert property (@(posedge clk) disable iff (reset) enq_en |-> not_full);
    assert property (@(posedge clk) disable iff (reset) deq_en |-> not_empty);

endmodule

// ==== src/hc_pkg.sv ====
package hc_pkg;

    // ============================================================
    // Sizing defaults, overridden from the top level
    // ============================================================

    // Ring of 64 entries unless the top level says otherwise
    localparam int RING_IDX_BITS_DEFAULT = 6;

    // Idle counter fires when its top bit sets, 16 cycles for 5 bits
    localparam int IDLE_FLUSH_BITS_DEFAULT = 5;

    // ============================================================
    // Payload and address types
    // ============================================================

    typedef logic [63:0] cl_data_t;
    typedef logic [31:0] line_addr_t;
    typedef logic [RING_IDX_BITS_DEFAULT-1:0] ring_idx_t;

    // Kind of write sent to host memory
    typedef enum logic
    {
        REQ_WRLINE = 1'b0,
        REQ_FENCE  = 1'b1
    } req_kind_t;

    // One memory write request as it crosses to the host port
    typedef struct packed
    {
        req_kind_t  kind;
        line_addr_t addr;
        cl_data_t   data;
    } wr_req_t;

    // Control inputs that would otherwise live in a CSR block
    typedef struct packed
    {
        logic       enable;
        line_addr_t base_addr;
    } hc_csr_t;

    // Per-cycle answer from the write channel to the ring writer
    typedef struct packed
    {
        logic grant;
        logic can_issue;
    } channel_grant_t;

    // Host-side view handed back to the ring writer
    typedef struct packed
    {
        ring_idx_t oldest_idx;
    } ring_status_t;

endpackage
